//--- rtl/ntm_consts.svh
// Size and fixed-point constants for the NTM memory core, include wherever sizes are needed
`ifndef NTM_CONSTS_SVH
`define NTM_CONSTS_SVH

////////////////////////////////////////////////////////////
// Matrix geometry
////////////////////////////////////////////////////////////

// Rows, one weight each
`define NTM_N 8
// Columns, one erase and one add value each
`define NTM_W 8

////////////////////////////////////////////////////////////
// Word and fixed-point formats
////////////////////////////////////////////////////////////

// Unsigned memory word, wraps mod 2^16
`define NTM_WORD_BITS 16
// Q1.7 weight or erase value
`define NTM_WEIGHT_BITS 8
// Fraction bits, so 128 is 1.0
`define NTM_FRAC_BITS 7
// Read sum of N word x weight products
`define NTM_ACC_BITS 27

// Index widths
`define NTM_ROW_BITS 3
`define NTM_COL_BITS 3

`endif

//--- rtl/ntm_memory.sv
// N x W memory matrix with row-major external load, async element read and one write port
`timescale 1ns/1ps
`include "ntm_consts.svh"

module ntm_memory (
  input  logic          CLK,
  input  logic          RST,
  // External load, row 0 column 0 first
  input  logic          load,
  input  ntm_pkg::word_t load_data,
  // Element read, combinational
  input  ntm_pkg::row_t  rd_row,
  input  ntm_pkg::col_t  rd_col,
  output ntm_pkg::word_t rd_data,
  // Element write, registered
  input  logic          wr_en,
  input  ntm_pkg::row_t  wr_row,
  input  ntm_pkg::col_t  wr_col,
  input  ntm_pkg::word_t wr_data
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Matrix and load pointer
  ////////////////////////////////////////////////////////////

  word_t mem [`NTM_N][`NTM_W];

  row_t ld_row;
  col_t ld_col;
  logic ld_col_last;
  logic ld_row_last;

  assign ld_col_last = (ld_col == col_t'(`NTM_W - 1));
  assign ld_row_last = (ld_row == row_t'(`NTM_N - 1));

  // Column inner, row outer, whole matrix wraps to 0,0
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ld_row <= '0;
      ld_col <= '0;
    end else if (load) begin
      if (ld_col_last) begin
        ld_col <= '0;
        if (ld_row_last) begin
          ld_row <= '0;
        end else begin
          ld_row <= ld_row + 1'b1;
        end
      end else begin
        ld_col <= ld_col + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Loads only happen while idle, head writes only while busy,
  // so the two never meet; head write is checked first anyway
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int j = 0; j < `NTM_N; j++) begin
        for (int k = 0; k < `NTM_W; k++) begin
          mem[j][k] <= '0;
        end
      end
    end else if (wr_en) begin
      mem[wr_row][wr_col] <= wr_data;
    end else if (load) begin
      mem[ld_row][ld_col] <= load_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Same-cycle read lets a head write back in the cycle it reads
  assign rd_data = mem[rd_row][rd_col];

endmodule

//--- rtl/ntm_pkg.sv
// Shared types of the NTM memory core, imported by the head, memory and top modules
`include "ntm_consts.svh"

package ntm_pkg;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  // Memory word and add value
  typedef logic [`NTM_WORD_BITS-1:0] word_t;

  // Q1.7 weight or erase value
  typedef logic [`NTM_WEIGHT_BITS-1:0] weight_t;

  // Read accumulator, wide enough for N full products
  typedef logic [`NTM_ACC_BITS-1:0] acc_t;

  ////////////////////////////////////////////////////////////
  // Index and control types
  ////////////////////////////////////////////////////////////

  typedef logic [`NTM_ROW_BITS-1:0] row_t;
  typedef logic [`NTM_COL_BITS-1:0] col_t;

  // Top step sequence, read pass then write pass
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_READ  = 2'd1,
    SEQ_WRITE = 2'd2
  } seq_state_t;

endpackage

//--- rtl/ntm_read_head.sv
// Read head, walks columns and emits r(k) = sum_j w(j)*M(j,k) >> 7 once per column
`timescale 1ns/1ps
`include "ntm_consts.svh"

module ntm_read_head (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  ntm_pkg::weight_t w_vec [`NTM_N],
  // Memory read port
  output ntm_pkg::row_t    rd_row,
  output ntm_pkg::col_t    rd_col,
  input  ntm_pkg::word_t   rd_data,
  // Result stream, one word every N cycles
  output ntm_pkg::word_t   r_out,
  output logic             r_valid,
  output logic             done
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Walk state
  ////////////////////////////////////////////////////////////

  logic busy;
  row_t row_idx;
  col_t col_idx;
  acc_t acc;

  logic row_last;
  logic col_last;

  // Row is the inner index for a read
  assign row_last = (row_idx == row_t'(`NTM_N - 1));
  assign col_last = (col_idx == col_t'(`NTM_W - 1));

  assign rd_row = row_idx;
  assign rd_col = col_idx;

  ////////////////////////////////////////////////////////////
  // Multiply-accumulate
  ////////////////////////////////////////////////////////////

  acc_t prod;
  acc_t acc_next;

  // 16 x 8 product, N of them fit the accumulator
  assign prod     = acc_t'(rd_data) * acc_t'(w_vec[row_idx]);
  assign acc_next = acc + prod;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      row_idx <= '0;
      col_idx <= '0;
      acc     <= '0;
      r_valid <= 1'b0;
      done    <= 1'b0;
    end else begin
      // Pulses by default
      r_valid <= 1'b0;
      done    <= 1'b0;
      if (start && !busy) begin
        busy    <= 1'b1;
        row_idx <= '0;
        col_idx <= '0;
        acc     <= '0;
      end else if (busy) begin
        if (row_last) begin
          // Column complete, fresh sum for the next one
          row_idx <= '0;
          acc     <= '0;
          r_valid <= 1'b1;
          if (col_last) begin
            col_idx <= '0;
            busy    <= 1'b0;
            done    <= 1'b1;
          end else begin
            col_idx <= col_idx + 1'b1;
          end
        end else begin
          row_idx <= row_idx + 1'b1;
          acc     <= acc_next;
        end
      end
    end
  end

  // Result word, drop fraction then truncate to 16 bits
  always_ff @(posedge CLK) begin
    if (busy && row_last) begin
      r_out <= word_t'(acc_next >> `NTM_FRAC_BITS);
    end
  end

endmodule

//--- rtl/ntm_top.sv
// NTM memory core top, runs one read pass then one write pass per start and gates the loads
`timescale 1ns/1ps
`include "ntm_consts.svh"

module ntm_top (
  input  logic             CLK,
  input  logic             RST,
  // Control
  input  logic             start,
  output logic             ready,
  // Operand loads, taken only while idle
  input  logic             w_in_enable,
  input  ntm_pkg::weight_t w_in,
  input  logic             e_in_enable,
  input  ntm_pkg::weight_t e_in,
  input  logic             a_in_enable,
  input  ntm_pkg::word_t   a_in,
  input  logic             m_in_enable,
  input  ntm_pkg::word_t   m_in,
  // Read result stream
  output logic             r_out_enable,
  output ntm_pkg::word_t   r_out
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Step sequencer
  ////////////////////////////////////////////////////////////

  seq_state_t state;
  logic       idle;
  logic       rd_start;
  logic       rd_done;
  logic       wr_start;
  logic       wr_done;

  assign idle = (state == SEQ_IDLE);

  // Head starts are same-cycle pulses, each head begins next edge
  assign rd_start = idle && start;
  assign wr_start = (state == SEQ_READ) && rd_done;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= SEQ_IDLE;
      ready <= 1'b0;
    end else begin
      // One-cycle ready at the end of a run
      ready <= 1'b0;
      case (state)
        // Step 0, wait for start
        SEQ_IDLE: begin
          if (start) begin
            state <= SEQ_READ;
          end
        end
        // Step 1, read pass
        SEQ_READ: begin
          if (rd_done) begin
            state <= SEQ_WRITE;
          end
        end
        // Step 2, erase and add pass
        SEQ_WRITE: begin
          if (wr_done) begin
            state <= SEQ_IDLE;
            ready <= 1'b1;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand buffers
  ////////////////////////////////////////////////////////////

  weight_t w_vec [`NTM_N];
  weight_t e_vec [`NTM_W];
  word_t   a_vec [`NTM_W];

  // Strobes during a run are dropped
  logic w_load;
  logic e_load;
  logic a_load;
  logic m_load;

  assign w_load = w_in_enable && idle;
  assign e_load = e_in_enable && idle;
  assign a_load = a_in_enable && idle;
  assign m_load = m_in_enable && idle;

  // Weighting, one per row
  ntm_vector_buffer #(
    .payload_t (weight_t),
    .LEN       (`NTM_N)
  ) i_w_buf (
    .CLK       (CLK),
    .RST       (RST),
    .load      (w_load),
    .load_data (w_in),
    .vec       (w_vec)
  );

  // Erase vector, one per column
  ntm_vector_buffer #(
    .payload_t (weight_t),
    .LEN       (`NTM_W)
  ) i_e_buf (
    .CLK       (CLK),
    .RST       (RST),
    .load      (e_load),
    .load_data (e_in),
    .vec       (e_vec)
  );

  // Add vector, full words
  ntm_vector_buffer #(
    .payload_t (word_t),
    .LEN       (`NTM_W)
  ) i_a_buf (
    .CLK       (CLK),
    .RST       (RST),
    .load      (a_load),
    .load_data (a_in),
    .vec       (a_vec)
  );

  ////////////////////////////////////////////////////////////
  // Memory and address mux
  ////////////////////////////////////////////////////////////

  row_t  rh_row;
  col_t  rh_col;
  row_t  wh_row;
  col_t  wh_col;
  row_t  mem_rd_row;
  col_t  mem_rd_col;
  word_t mem_rd_data;
  logic  wh_wr_en;
  word_t wh_wr_data;

  // One pass at a time, state picks the active head
  assign mem_rd_row = (state == SEQ_WRITE) ? wh_row : rh_row;
  assign mem_rd_col = (state == SEQ_WRITE) ? wh_col : rh_col;

  ntm_memory i_memory (
    .CLK       (CLK),
    .RST       (RST),
    .load      (m_load),
    .load_data (m_in),
    .rd_row    (mem_rd_row),
    .rd_col    (mem_rd_col),
    .rd_data   (mem_rd_data),
    .wr_en     (wh_wr_en),
    .wr_row    (wh_row),
    .wr_col    (wh_col),
    .wr_data   (wh_wr_data)
  );

  ////////////////////////////////////////////////////////////
  // Heads
  ////////////////////////////////////////////////////////////

  ntm_read_head i_read_head (
    .CLK     (CLK),
    .RST     (RST),
    .start   (rd_start),
    .w_vec   (w_vec),
    .rd_row  (rh_row),
    .rd_col  (rh_col),
    .rd_data (mem_rd_data),
    .r_out   (r_out),
    .r_valid (r_out_enable),
    .done    (rd_done)
  );

  // Writes back at its own read address
  ntm_write_head i_write_head (
    .CLK     (CLK),
    .RST     (RST),
    .start   (wr_start),
    .w_vec   (w_vec),
    .e_vec   (e_vec),
    .a_vec   (a_vec),
    .rd_row  (wh_row),
    .rd_col  (wh_col),
    .rd_data (mem_rd_data),
    .wr_en   (wh_wr_en),
    .wr_data (wh_wr_data),
    .done    (wr_done)
  );

endmodule

//--- rtl/ntm_vector_buffer.sv
// Strobe-loaded register vector, instantiated by the top for the w, e and a operands
`timescale 1ns/1ps

module ntm_vector_buffer #(
  parameter type payload_t = logic [7:0],
  parameter int  LEN       = 8
) (
  input  logic     CLK,
  input  logic     RST,
  input  logic     load,
  input  payload_t load_data,
  output payload_t vec [LEN]
);

  // Index wide enough for LEN, at least one bit
  localparam int IDX_BITS = (LEN > 1) ? $clog2(LEN) : 1;

  ////////////////////////////////////////////////////////////
  // Load pointer
  ////////////////////////////////////////////////////////////

  logic [IDX_BITS-1:0] idx;
  logic                idx_last;

  // Last slot, next strobe wraps to zero
  assign idx_last = (idx == IDX_BITS'(LEN - 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      idx <= '0;
    end else if (load) begin
      if (idx_last) begin
        idx <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Cleared on reset so an unloaded operand reads as zero
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < LEN; i++) begin
        vec[i] <= '0;
      end
    end else if (load) begin
      vec[idx] <= load_data;
    end
  end

endmodule

//--- rtl/ntm_write_head.sv
// Write head, erases then adds on every element in row-major order, one element per cycle
`timescale 1ns/1ps
`include "ntm_consts.svh"

module ntm_write_head (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  ntm_pkg::weight_t w_vec [`NTM_N],
  input  ntm_pkg::weight_t e_vec [`NTM_W],
  input  ntm_pkg::word_t   a_vec [`NTM_W],
  // Read address doubles as write address
  output ntm_pkg::row_t    rd_row,
  output ntm_pkg::col_t    rd_col,
  input  ntm_pkg::word_t   rd_data,
  output logic             wr_en,
  output ntm_pkg::word_t   wr_data,
  output logic             done
);

  import ntm_pkg::*;

  // M*w*e, three factors
  localparam int ERASE_BITS = `NTM_WORD_BITS + 2 * `NTM_WEIGHT_BITS;
  // w*a
  localparam int ADD_BITS   = `NTM_WORD_BITS + `NTM_WEIGHT_BITS;

  ////////////////////////////////////////////////////////////
  // Walk state
  ////////////////////////////////////////////////////////////

  logic busy;
  row_t row_idx;
  col_t col_idx;

  logic row_last;
  logic col_last;

  assign row_last = (row_idx == row_t'(`NTM_N - 1));
  assign col_last = (col_idx == col_t'(`NTM_W - 1));

  // Column inner, row outer
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      row_idx <= '0;
      col_idx <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy    <= 1'b1;
        row_idx <= '0;
        col_idx <= '0;
      end else if (busy) begin
        if (col_last) begin
          col_idx <= '0;
          if (row_last) begin
            row_idx <= '0;
            busy    <= 1'b0;
            done    <= 1'b1;
          end else begin
            row_idx <= row_idx + 1'b1;
          end
        end else begin
          col_idx <= col_idx + 1'b1;
        end
      end
    end
  end

  assign rd_row = row_idx;
  assign rd_col = col_idx;

  ////////////////////////////////////////////////////////////
  // Element update
  ////////////////////////////////////////////////////////////

  logic [ERASE_BITS-1:0] erase_prod;
  logic [ADD_BITS-1:0]   add_prod;
  word_t                 erase_term;
  word_t                 add_term;

  // Erase term, two Q1.7 factors so drop 14 bits
  assign erase_prod = ERASE_BITS'(rd_data) * ERASE_BITS'(w_vec[row_idx])
                    * ERASE_BITS'(e_vec[col_idx]);
  assign erase_term = word_t'(erase_prod >> (2 * `NTM_FRAC_BITS));

  // Add term, one Q1.7 factor
  assign add_prod = ADD_BITS'(a_vec[col_idx]) * ADD_BITS'(w_vec[row_idx]);
  assign add_term = word_t'(add_prod >> `NTM_FRAC_BITS);

  // Erase first, then add, both wrap mod 2^16
  assign wr_data = rd_data - erase_term + add_term;
  assign wr_en   = busy;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the NTM testbench with Verilator, fail if the log reports failure
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module ntm_tb -f tb.f -o ntm_sim > build.log 2>&1 \
  && ./obj_dir/ntm_sim > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "Testbench failed" sim.log \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- tb.f
+incdir+rtl
rtl/ntm_pkg.sv
rtl/ntm_vector_buffer.sv
rtl/ntm_memory.sv
rtl/ntm_read_head.sv
rtl/ntm_write_head.sv
rtl/ntm_top.sv
test/ntm_tb.sv

//--- test/ntm_tb.sv
// Directed testbench for the NTM memory core, compile with tb.f and run ntm_tb as the top
`timescale 1ns/1ps
`include "ntm_consts.svh"

module ntm_tb;

  import ntm_pkg::*;

  localparam int N = `NTM_N;
  localparam int W = `NTM_W;
  // About 55 runs of ~150 cycles each plus memory loads, with wide margin
  localparam int TIMEOUT_CYCLES = 40000;

  ////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////

  logic    CLK;
  logic    RST;
  logic    start;
  logic    ready;
  logic    w_in_enable;
  weight_t w_in;
  logic    e_in_enable;
  weight_t e_in;
  logic    a_in_enable;
  word_t   a_in;
  logic    m_in_enable;
  word_t   m_in;
  logic    r_out_enable;
  word_t   r_out;

  ntm_top i_ntm_top (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .ready        (ready),
    .w_in_enable  (w_in_enable),
    .w_in         (w_in),
    .e_in_enable  (e_in_enable),
    .e_in         (e_in),
    .a_in_enable  (a_in_enable),
    .a_in         (a_in),
    .m_in_enable  (m_in_enable),
    .m_in         (m_in),
    .r_out_enable (r_out_enable),
    .r_out        (r_out)
  );

  // 10 ns period
  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Model state and bookkeeping
  ////////////////////////////////////////////////////////////

  logic [15:0] model_mem [N][W];
  logic [7:0]  w_cur [N];
  logic [7:0]  e_cur [W];
  logic [15:0] a_cur [W];
  logic [15:0] r_seen [$];
  logic [31:0] lfsr_state;
  string       test_name;
  int          errors = 0;
  int          checks = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          ready_pulses = 0;
  int          read_pulses = 0;
  int          cycle_count = 0;

  // Global pulse counters, outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (ready) begin
      ready_pulses++;
    end
    if (r_out_enable) begin
      read_pulses++;
    end
  end

  // Watchdog
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and reporting
  ////////////////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic compare_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("mismatch in %s, %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string text);
    errors++;
    test_errors++;
    $display("error in %s: %s", test_name, text);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished with %0d errors", test_name, test_errors);
  endtask

  ////////////////////////////////////////////////////////////
  // Expected values from the fixed-point rules
  ////////////////////////////////////////////////////////////

  // r(k) = sum_j w(j)*M(j,k), drop 7 fraction bits, keep 16
  function automatic logic [15:0] expected_read(input int k);
    logic [31:0] sum;
    sum = '0;
    for (int j = 0; j < N; j++) begin
      sum = sum + 32'(model_mem[j][k]) * 32'(w_cur[j]);
    end
    return 16'(sum >> 7);
  endfunction

  // Erase then add, each term wraps mod 2^16
  task automatic apply_write_model();
    logic [39:0] erase_full;
    logic [31:0] add_full;
    for (int j = 0; j < N; j++) begin
      for (int k = 0; k < W; k++) begin
        erase_full = 40'(model_mem[j][k]) * 40'(w_cur[j]) * 40'(e_cur[k]);
        add_full   = 32'(a_cur[k]) * 32'(w_cur[j]);
        model_mem[j][k] = model_mem[j][k] - 16'(erase_full >> 14) + 16'(add_full >> 7);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  // w, e and a side by side, one element per strobe
  task automatic load_operands();
    int len;
    len = (N > W) ? N : W;
    for (int i = 0; i < len; i++) begin
      @(negedge CLK);
      w_in_enable = (i < N);
      w_in        = (i < N) ? w_cur[i] : '0;
      e_in_enable = (i < W);
      e_in        = (i < W) ? e_cur[i] : '0;
      a_in_enable = (i < W);
      a_in        = (i < W) ? a_cur[i] : '0;
    end
    @(negedge CLK);
    w_in_enable = 1'b0;
    e_in_enable = 1'b0;
    a_in_enable = 1'b0;
  endtask

  // Row-major, row 0 column 0 first
  task automatic load_memory();
    for (int j = 0; j < N; j++) begin
      for (int k = 0; k < W; k++) begin
        @(negedge CLK);
        m_in_enable = 1'b1;
        m_in        = model_mem[j][k];
      end
    end
    @(negedge CLK);
    m_in_enable = 1'b0;
  endtask

  // One START, collect read words until ready, optionally poke the DUT while busy
  task automatic run_pass(input bit disturb);
    int cycle;
    int pulses;
    int last_pulse;
    bit seen_ready;
    r_seen.delete();
    cycle      = 0;
    pulses     = 0;
    last_pulse = 0;
    seen_ready = 1'b0;
    @(negedge CLK);
    start = 1'b1;
    while (!seen_ready) begin
      @(negedge CLK);
      cycle++;
      // Drop any strobe from the previous cycle
      start       = 1'b0;
      m_in_enable = 1'b0;
      w_in_enable = 1'b0;
      e_in_enable = 1'b0;
      a_in_enable = 1'b0;
      if (r_out_enable) begin
        if (pulses > 0 && cycle - last_pulse != N) begin
          report_failure($sformatf("read words %0d cycles apart", cycle - last_pulse));
        end
        r_seen.push_back(r_out);
        pulses++;
        last_pulse = cycle;
      end
      if (ready) begin
        seen_ready = 1'b1;
      end else if (disturb && cycle % 20 == 7) begin
        // Junk that must be lost while busy
        start       = 1'b1;
        m_in_enable = 1'b1;
        m_in        = 16'hdead;
        w_in_enable = 1'b1;
        w_in        = 8'hff;
        e_in_enable = 1'b1;
        e_in        = 8'hff;
        a_in_enable = 1'b1;
        a_in        = 16'hbeef;
      end
    end
    compare_value("read pulses per run", 16'(W), 16'(pulses));
  endtask

  // One-hot w at row j, zero e and a, returns row j and leaves memory alone
  task automatic check_row(input int j);
    for (int i = 0; i < N; i++) begin
      w_cur[i] = (i == j) ? 8'd128 : 8'd0;
    end
    for (int k = 0; k < W; k++) begin
      e_cur[k] = '0;
      a_cur[k] = '0;
    end
    load_operands();
    run_pass(1'b0);
    if (r_seen.size() == W) begin
      for (int k = 0; k < W; k++) begin
        compare_value($sformatf("row %0d col %0d", j, k), model_mem[j][k], r_seen[k]);
      end
    end
  endtask

  task automatic check_all_rows();
    for (int j = 0; j < N; j++) begin
      check_row(j);
    end
  endtask

  task automatic check_read_words();
    if (r_seen.size() == W) begin
      for (int k = 0; k < W; k++) begin
        compare_value($sformatf("r(%0d)", k), expected_read(k), r_seen[k]);
      end
    end
  endtask

  // Fresh random operands, widths per format
  task automatic randomize_operands(input int w_bits);
    for (int j = 0; j < N; j++) begin
      w_cur[j] = 8'(random_bits(w_bits));
    end
    for (int k = 0; k < W; k++) begin
      e_cur[k] = 8'(random_bits(8));
      a_cur[k] = 16'(random_bits(16));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    begin_test("reset");
    RST = 1'b1;
    repeat (4) begin
      @(negedge CLK);
      if (ready || r_out_enable) begin
        report_failure("ready or r_out_enable high during reset");
      end
    end
    RST = 1'b0;
    repeat (10) begin
      @(negedge CLK);
      if (ready || r_out_enable) begin
        report_failure("ready or r_out_enable high after reset without a start");
      end
    end
    check_all_rows();
    end_test();
  endtask

  task automatic test_load_readback();
    begin_test("load_readback");
    for (int j = 0; j < N; j++) begin
      for (int k = 0; k < W; k++) begin
        model_mem[j][k] = 16'(random_bits(16));
      end
    end
    load_memory();
    check_all_rows();
    end_test();
  endtask

  task automatic test_weighted_read();
    begin_test("weighted_read");
    repeat (3) begin
      for (int j = 0; j < N; j++) begin
        // Each weight at most 32
        w_cur[j] = 8'(random_bits(6) % 33);
      end
      for (int k = 0; k < W; k++) begin
        e_cur[k] = '0;
        a_cur[k] = '0;
      end
      load_operands();
      run_pass(1'b0);
      check_read_words();
    end
    end_test();
  endtask

  task automatic test_erase_add_row();
    logic [15:0] a_saved [W];
    begin_test("erase_add_row");
    for (int j = 0; j < N; j++) begin
      w_cur[j] = (j == 2) ? 8'd128 : 8'd0;
    end
    for (int k = 0; k < W; k++) begin
      e_cur[k]   = 8'd128;
      a_cur[k]   = 16'(random_bits(16));
      a_saved[k] = a_cur[k];
    end
    load_operands();
    run_pass(1'b0);
    // Read pass sees the old row 2
    check_read_words();
    // Full erase then full add, row 2 becomes a
    for (int k = 0; k < W; k++) begin
      model_mem[2][k] = a_saved[k];
    end
    check_all_rows();
    end_test();
  endtask

  task automatic test_random_update();
    begin_test("random_update");
    repeat (2) begin
      randomize_operands(8);
      load_operands();
      run_pass(1'b0);
      check_read_words();
      apply_write_model();
      check_all_rows();
    end
    end_test();
  endtask

  task automatic test_busy();
    int ready_before;
    int read_before;
    begin_test("busy");
    randomize_operands(8);
    load_operands();
    ready_before = ready_pulses;
    read_before  = read_pulses;
    run_pass(1'b1);
    check_read_words();
    apply_write_model();
    // Long enough for a stray run to show up
    repeat (2 * N * W + 20) begin
      @(negedge CLK);
    end
    compare_value("ready pulses", 16'd1, 16'(ready_pulses - ready_before));
    compare_value("read pulses", 16'(W), 16'(read_pulses - read_before));
    check_all_rows();
    end_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    CLK         = 1'b0;
    RST         = 1'b1;
    start       = 1'b0;
    w_in_enable = 1'b0;
    w_in        = '0;
    e_in_enable = 1'b0;
    e_in        = '0;
    a_in_enable = 1'b0;
    a_in        = '0;
    m_in_enable = 1'b0;
    m_in        = '0;
    lfsr_state  = 32'hb6e1_7d16;
    for (int j = 0; j < N; j++) begin
      for (int k = 0; k < W; k++) begin
        model_mem[j][k] = '0;
      end
    end
    test_reset();
    test_load_readback();
    test_weighted_read();
    test_erase_add_row();
    test_random_update();
    test_busy();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
